// File: fsq_top.f
+incdir+.
fsq_pkg.sv
fsq_ram.sv
fsq_pointers.sv
fsq_cache_issue.sv
fsq_commit.sv
fsq_top.sv
tb_fsq.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fsq
FILELIST  = fsq_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_fsq_tasks.svh
`ifndef TB_FSQ_TASKS_SVH
`define TB_FSQ_TASKS_SVH

// next cycle, inputs change 1 ns after the edge
task automatic step();
    int rnd;
    @(posedge clk);
    #1;
    if (ready_random) begin
        rnd = $random(seed);
        cache_ready = rnd[0];
    end
endtask

task automatic apply_reset();
    rst = 1'b1;
    pred_en = 1'b0;
    pred_stream = '0;
    cache_ready = 1'b1;
    redirect_en = 1'b0;
    redirect_idx = '0;
    redirect_offset = '0;
    redirect_taken = 1'b0;
    redirect_target = '0;
    redirect_br_type = fsq_pkg::CONDITION;
    commit_num = '0;
    ready_random = 1'b0;
    model_tail = 0;
    squash_cnt = 0;
    iss_idx_q.delete();
    iss_stream_q.delete();
    upd_q.delete();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
endtask

// fields follow from the sequence number alone
function automatic fsq_pkg::fetch_stream_t make_stream(input int n);
    fsq_pkg::fetch_stream_t s;
    s.start_addr = 'h1_0000 + n * 'h100;
    s.target     = 'h4_0000 + n * 'h24;
    s.size       = PW'((n * 5 + 1) % 8);
    s.taken      = n[0];
    return s;
endfunction

task automatic enqueue(input fsq_pkg::fetch_stream_t s);
    compare_bit(pred_stall, 1'b0, "pred_stall before enqueue");
    compare_idx(pred_stream_idx, IDX_W'(model_tail), "pred_stream_idx");
    pred_en = 1'b1;
    pred_stream = s;
    exp_mem[model_tail] = s;
    model_tail = (model_tail + 1) % FSQ_SIZE;
    step();
    pred_en = 1'b0;
endtask

// at most COMMIT_WIDTH retired per cycle
task automatic retire_insts(input int total);
    int left;
    left = total;
    while (left > 0) begin
        commit_num = CNT_W'((left > COMMIT_WIDTH) ? COMMIT_WIDTH : left);
        left -= int'(commit_num);
        step();
    end
    commit_num = '0;
endtask

function automatic int recorded(input bit updates);
    return updates ? upd_q.size() : iss_idx_q.size();
endfunction

task automatic wait_records(input bit updates, input int n, input string what);
    int cycles;
    cycles = 0;
    while (recorded(updates) < n && cycles < WAIT_CYCLES) begin
        step();
        cycles++;
    end
    if (recorded(updates) < n) begin
        timeout_errors++;
        $display("timeout: only %0d of %0d %s arrived", recorded(updates), n, what);
    end
endtask

task automatic compare_stream(input fsq_pkg::fetch_stream_t got,
                              input fsq_pkg::fetch_stream_t want, input string msg);
    if (got !== want) begin
        value_errors++;
        $display("ERROR %0t: %s got %h expected %h", $time, msg, got, want);
    end
endtask

task automatic compare_idx(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] want,
                           input string msg);
    if (got !== want) begin
        value_errors++;
        $display("ERROR %0t: %s got %0d expected %0d", $time, msg, got, want);
    end
endtask

task automatic compare_addr(input logic [AW-1:0] got, input logic [AW-1:0] want,
                            input string msg);
    if (got !== want) begin
        value_errors++;
        $display("ERROR %0t: %s got %h expected %h", $time, msg, got, want);
    end
endtask

task automatic compare_bit(input logic got, input logic want, input string msg);
    if (got !== want) begin
        value_errors++;
        $display("ERROR %0t: %s got %b expected %b", $time, msg, got, want);
    end
endtask

task automatic check_update(input update_rec_t got, input fsq_pkg::fetch_stream_t want,
                            input logic err);
    compare_addr(got.start_addr, want.start_addr, "update_start_addr");
    compare_addr(got.target, want.target, "update_target");
    compare_bit(got.taken, want.taken, "update_taken");
    compare_bit(got.pred_error, err, "update_pred_error");
endtask

`endif

// File: tb_fsq.sv
`timescale 1ns/1ns

module tb_fsq;

    localparam int FSQ_SIZE     = 8;
    localparam int COMMIT_WIDTH = 4;
    localparam int IDX_W        = $clog2(FSQ_SIZE);
    localparam int CNT_W        = $clog2(COMMIT_WIDTH + 1);
    localparam int PW           = fsq_pkg::PREDICTION_WIDTH;
    localparam int AW           = fsq_pkg::VADDR_SIZE;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_CYCLES  = 100;
    // resets, handshake waits, worst-case commit traffic and idle cycles
    localparam int TEST_CYCLES  = 3 * (RESET_CYCLES + 1) + 3 * WAIT_CYCLES
                                  + 2 * FSQ_SIZE * fsq_pkg::BLOCK_INSTS + 4 * FSQ_SIZE;
    localparam int MARGIN       = 50;

    typedef struct packed {
        logic [AW-1:0] start_addr;
        logic [AW-1:0] target;
        logic          taken;
        logic          pred_error;
    } update_rec_t;

    logic                   clk;
    logic                   rst;
    logic                   pred_en;
    fsq_pkg::fetch_stream_t pred_stream;
    logic                   pred_stall;
    logic [IDX_W-1:0]       pred_stream_idx;
    logic                   cache_en;
    logic [IDX_W-1:0]       cache_idx;
    fsq_pkg::fetch_stream_t cache_stream;
    logic                   cache_ready;
    logic                   redirect_en;
    logic [IDX_W-1:0]       redirect_idx;
    logic [PW-1:0]          redirect_offset;
    logic                   redirect_taken;
    logic [AW-1:0]          redirect_target;
    fsq_pkg::br_type_e      redirect_br_type;
    logic [CNT_W-1:0]       commit_num;
    logic                   squash;
    logic [AW-1:0]          squash_target;
    logic                   update_en;
    logic [AW-1:0]          update_start_addr;
    logic [AW-1:0]          update_target;
    logic                   update_taken;
    logic                   update_pred_error;

    integer                 seed = 16592;
    int                     value_errors = 0;
    int                     timeout_errors = 0;
    bit                     ready_random;
    int                     model_tail;
    int                     squash_cnt;
    update_rec_t            mon_rec;
    fsq_pkg::fetch_stream_t exp_mem [FSQ_SIZE];
    logic [IDX_W-1:0]       iss_idx_q [$];
    fsq_pkg::fetch_stream_t iss_stream_q [$];
    update_rec_t            upd_q [$];

    fsq_top #(.FSQ_SIZE(FSQ_SIZE), .COMMIT_WIDTH(COMMIT_WIDTH)) UUT (.*);

    `include "tb_fsq_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sampled mid-cycle, after the drive and before the next edge
    always @(negedge clk) begin
        if (cache_en && cache_ready) begin
            iss_idx_q.push_back(cache_idx);
            iss_stream_q.push_back(cache_stream);
        end
        if (update_en) begin
            mon_rec.start_addr = update_start_addr;
            mon_rec.target     = update_target;
            mon_rec.taken      = update_taken;
            mon_rec.pred_error = update_pred_error;
            upd_q.push_back(mon_rec);
        end
        if (squash) begin
            squash_cnt++;
        end
    end

    task automatic check_reset();
        compare_bit(cache_en, 1'b0, "cache_en after reset");
        compare_bit(squash, 1'b0, "squash after reset");
        compare_bit(update_en, 1'b0, "update_en after reset");
        compare_bit(pred_stall, 1'b0, "pred_stall after reset");
        compare_idx(pred_stream_idx, '0, "pred_stream_idx after reset");
    endtask

    task automatic issue_in_order(input int n);
        ready_random = 1'b1;
        for (int i = 0; i < n; i++) begin
            enqueue(make_stream(i));
        end
        wait_records(1'b0, n, "cache requests");
        ready_random = 1'b0;
        cache_ready = 1'b1;
        for (int i = 0; i < n && i < iss_idx_q.size(); i++) begin
            compare_idx(iss_idx_q[i], IDX_W'(i), "cache_idx");
            compare_stream(iss_stream_q[i], exp_mem[i], "cache_stream");
        end
    endtask

    task automatic fill_queue();
        for (int i = 0; i < FSQ_SIZE; i++) begin
            enqueue(make_stream(i));
        end
        compare_bit(pred_stall, 1'b1, "pred_stall when full");
        pred_en = 1'b1;
        pred_stream = make_stream(99);
        step();
        pred_en = 1'b0;
        compare_idx(pred_stream_idx, IDX_W'(model_tail), "pred_stream_idx after stalled enqueue");
        compare_bit(pred_stall, 1'b1, "pred_stall still full");
    endtask

    task automatic commit_streams(input int n);
        int insts;
        insts = 0;
        for (int i = 0; i < n; i++) begin
            insts += exp_mem[i].size + 1;
        end
        retire_insts(insts);
        wait_records(1'b1, n, "predictor updates");
        for (int i = 0; i < n && i < upd_q.size(); i++) begin
            check_update(upd_q[i], exp_mem[i], 1'b0);
        end
    endtask

    task automatic redirect_stream();
        fsq_pkg::fetch_stream_t fixed;
        cache_ready = 1'b0;
        for (int i = 0; i < 5; i++) begin
            enqueue(make_stream(i + 10));
        end
        // truncated stream as the backend resolved it
        fixed = exp_mem[2];
        fixed.size = PW'(2);
        fixed.target = 'h7_7700;
        fixed.taken = 1'b1;
        exp_mem[2] = fixed;
        redirect_en = 1'b1;
        redirect_idx = IDX_W'(2);
        redirect_offset = fixed.size;
        redirect_taken = fixed.taken;
        redirect_target = fixed.target;
        redirect_br_type = fsq_pkg::CONDITION;
        step();
        redirect_en = 1'b0;
        model_tail = 3;
        compare_bit(cache_en, 1'b0, "cache_en after redirect");
        compare_bit(squash, 1'b1, "squash after redirect");
        compare_addr(squash_target, fixed.target, "squash_target");
        compare_idx(pred_stream_idx, IDX_W'(model_tail), "pred_stream_idx after redirect");
        cache_ready = 1'b1;
        step();
        compare_bit(squash, 1'b0, "squash one cycle later");
        retire_insts(exp_mem[0].size + exp_mem[1].size + fixed.size + 3);
        wait_records(1'b1, 3, "updates after redirect");
        repeat (FSQ_SIZE) step();
        if (squash_cnt != 1 || upd_q.size() != 3) begin
            value_errors++;
            $display("ERROR %0t: %0d squash pulses and %0d updates, expected 1 and 3",
                     $time, squash_cnt, upd_q.size());
        end
        foreach (iss_idx_q[i]) begin
            if (iss_idx_q[i] == IDX_W'(3) || iss_idx_q[i] == IDX_W'(4)) begin
                value_errors++;
                $display("ERROR %0t: cache got dropped entry %0d", $time, iss_idx_q[i]);
            end
        end
        for (int i = 0; i < 3 && i < upd_q.size(); i++) begin
            check_update(upd_q[i], exp_mem[i], i == 2);
        end
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        apply_reset();
        check_reset();
        issue_in_order(6);
        apply_reset();
        fill_queue();
        commit_streams(FSQ_SIZE);
        apply_reset();
        redirect_stream();
        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("Test OK");
        end
        else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: fsq_top.sv
`timescale 1ns/1ns

module fsq_top #(
    parameter int FSQ_SIZE     = 8,
    parameter int COMMIT_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    // predictor enqueue
    input  logic                                   pred_en,
    input  fsq_pkg::fetch_stream_t                 pred_stream,
    output logic                                   pred_stall,
    output logic [$clog2(FSQ_SIZE)-1:0]            pred_stream_idx,
    // instruction cache
    output logic                                   cache_en,
    output logic [$clog2(FSQ_SIZE)-1:0]            cache_idx,
    output fsq_pkg::fetch_stream_t                 cache_stream,
    input  logic                                   cache_ready,
    // backend redirect and commit
    input  logic                                   redirect_en,
    input  logic [$clog2(FSQ_SIZE)-1:0]            redirect_idx,
    input  logic [fsq_pkg::PREDICTION_WIDTH-1:0]   redirect_offset,
    input  logic                                   redirect_taken,
    input  logic [fsq_pkg::VADDR_SIZE-1:0]         redirect_target,
    input  fsq_pkg::br_type_e                      redirect_br_type,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0]      commit_num,
    // predictor squash and update
    output logic                                   squash,
    output logic [fsq_pkg::VADDR_SIZE-1:0]         squash_target,
    output logic                                   update_en,
    output logic [fsq_pkg::VADDR_SIZE-1:0]         update_start_addr,
    output logic [fsq_pkg::VADDR_SIZE-1:0]         update_target,
    output logic                                   update_taken,
    output logic                                   update_pred_error
);

    localparam int IDX_W = $clog2(FSQ_SIZE);

    logic                   full;
    logic                   enq;
    logic                   issue;
    logic                   retire;
    logic                   search_valid;
    logic [IDX_W-1:0]       tail;
    logic [IDX_W-1:0]       search_head;
    logic [IDX_W-1:0]       commit_head;
    logic [IDX_W-1:0]       search_addr;
    logic                   ram_we;
    logic [IDX_W-1:0]       ram_waddr;
    fsq_pkg::fetch_stream_t ram_wdata;
    fsq_pkg::fetch_stream_t search_data;
    fsq_pkg::fetch_stream_t commit_data;
    fsq_pkg::fetch_stream_t rewrite_stream;
    fsq_pkg::wb_info_t      wb_info;

    assign pred_stall      = full;
    assign pred_stream_idx = tail;

    // the rewrite owns the write port on a redirect cycle
    assign enq = pred_en & ~full & ~redirect_en;

    // the search port reads the redirected entry while the cache slot flushes
    assign search_addr = redirect_en ? redirect_idx : search_head;

    always_comb begin
        rewrite_stream.start_addr = search_data.start_addr;
        rewrite_stream.target     = redirect_target;
        rewrite_stream.size       = redirect_offset;
        rewrite_stream.taken      = redirect_taken;
        wb_info.taken             = redirect_taken;
        wb_info.br_type           = redirect_br_type;
        wb_info.target            = redirect_target;
        wb_info.offset            = redirect_offset;
    end

    assign ram_we    = redirect_en | enq;
    assign ram_waddr = redirect_en ? redirect_idx : tail;
    assign ram_wdata = redirect_en ? rewrite_stream : pred_stream;

    fsq_ram #(.FSQ_SIZE(FSQ_SIZE)) u_ram (
        .clk(clk), .rst(rst), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .search_addr(search_addr), .commit_addr(commit_head),
        .search_data(search_data), .commit_data(commit_data)
    );

    fsq_pointers #(.FSQ_SIZE(FSQ_SIZE)) u_pointers (
        .clk(clk), .rst(rst), .enq(enq), .issue(issue), .retire(retire),
        .redirect_en(redirect_en), .redirect_idx(redirect_idx),
        .tail(tail), .search_head(search_head), .commit_head(commit_head),
        .full(full), .search_valid(search_valid)
    );

    fsq_cache_issue #(.FSQ_SIZE(FSQ_SIZE)) u_cache_issue (
        .clk(clk), .rst(rst), .search_valid(search_valid), .search_idx(search_head),
        .search_stream(search_data), .cache_ready(cache_ready), .flush(redirect_en),
        .issue(issue), .cache_en(cache_en), .cache_idx(cache_idx),
        .cache_stream(cache_stream)
    );

    fsq_commit #(.FSQ_SIZE(FSQ_SIZE), .COMMIT_WIDTH(COMMIT_WIDTH)) u_commit (
        .clk(clk), .rst(rst), .enq(enq), .enq_idx(tail),
        .redirect_en(redirect_en), .redirect_idx(redirect_idx), .redirect_info(wb_info),
        .commit_head(commit_head), .head_stream(commit_data), .commit_num(commit_num),
        .retire(retire), .update_en(update_en), .update_start_addr(update_start_addr),
        .update_target(update_target), .update_taken(update_taken),
        .update_pred_error(update_pred_error)
    );

    // squash the predictor one cycle after the redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squash <= 1'b0;
        end
        else begin
            squash <= redirect_en;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_en) begin
            squash_target <= redirect_target;
        end
    end

endmodule

// File: fsq_commit.sv
`timescale 1ns/1ns

module fsq_commit #(
    parameter int FSQ_SIZE     = 8,
    parameter int COMMIT_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   enq,
    input  logic [$clog2(FSQ_SIZE)-1:0]            enq_idx,
    input  logic                                   redirect_en,
    input  logic [$clog2(FSQ_SIZE)-1:0]            redirect_idx,
    input  fsq_pkg::wb_info_t                      redirect_info,
    input  logic [$clog2(FSQ_SIZE)-1:0]            commit_head,
    input  fsq_pkg::fetch_stream_t                 head_stream,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0]      commit_num,
    output logic                                   retire,
    output logic                                   update_en,
    output logic [fsq_pkg::VADDR_SIZE-1:0]         update_start_addr,
    output logic [fsq_pkg::VADDR_SIZE-1:0]         update_target,
    output logic                                   update_taken,
    output logic                                   update_pred_error
);

    localparam int MAX_INSTS = FSQ_SIZE * fsq_pkg::BLOCK_INSTS;
    localparam int CNT_W     = $clog2(MAX_INSTS) + 1;

    fsq_pkg::wb_info_t  wb_tab [FSQ_SIZE];
    fsq_pkg::wb_info_t  head_wb;
    logic [FSQ_SIZE-1:0] pred_err;
    logic                head_err;
    logic [CNT_W-1:0]    inst_cnt;
    logic [CNT_W-1:0]    head_insts;
    logic [CNT_W-1:0]    retire_insts;

    // write-back info of the resolved branch
    always_ff @(posedge clk) begin
        if (redirect_en) begin
            wb_tab[redirect_idx] <= redirect_info;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_err <= '0;
        end
        else begin
            if (enq) begin
                pred_err[enq_idx] <= 1'b0;
            end
            if (redirect_en) begin
                pred_err[redirect_idx] <= 1'b1;
            end
        end
    end

    assign head_wb  = wb_tab[commit_head];
    assign head_err = pred_err[commit_head];

    // size already holds the redirect offset after a rewrite
    assign head_insts   = CNT_W'(head_stream.size) + CNT_W'(1);
    assign retire       = inst_cnt > CNT_W'(head_stream.size);
    assign retire_insts = retire ? head_insts : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inst_cnt <= '0;
        end
        else begin
            inst_cnt <= inst_cnt + CNT_W'(commit_num) - retire_insts;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            update_en <= 1'b0;
        end
        else begin
            update_en <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            update_start_addr <= head_stream.start_addr;
            update_taken      <= head_stream.taken;
            update_target     <= head_err ? head_wb.target : head_stream.target;
            update_pred_error <= head_err;
        end
    end

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (rst)
        inst_cnt <= CNT_W'(MAX_INSTS)
    ) else $error("fsq_commit: more retired instructions than queued");

endmodule

// File: fsq_cache_issue.sv
`timescale 1ns/1ns

module fsq_cache_issue #(
    parameter int FSQ_SIZE = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          search_valid,
    input  logic [$clog2(FSQ_SIZE)-1:0]   search_idx,
    input  fsq_pkg::fetch_stream_t        search_stream,
    input  logic                          cache_ready,
    input  logic                          flush,
    output logic                          issue,
    output logic                          cache_en,
    output logic [$clog2(FSQ_SIZE)-1:0]   cache_idx,
    output fsq_pkg::fetch_stream_t        cache_stream
);

    localparam logic [$clog2(FSQ_SIZE)-1:0] IDX_ONE = 1;

    logic slot_free;

    // slot can take a new stream when empty or being accepted
    assign slot_free = ~cache_en | cache_ready;
    assign issue     = slot_free & search_valid & ~flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cache_en <= 1'b0;
        end
        else if (flush) begin
            cache_en <= 1'b0;
        end
        else if (slot_free) begin
            cache_en <= search_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cache_idx    <= search_idx;
            cache_stream <= search_stream;
        end
    end

    // back-to-back requests follow the queue order
    a_issue_in_order: assert property (
        @(posedge clk) disable iff (rst)
        (cache_en && cache_ready && issue) |=>
            (cache_idx == $past(cache_idx) + IDX_ONE)
    ) else $error("fsq_cache_issue: request skipped or repeated a stream");

endmodule

// File: fsq_pointers.sv
`timescale 1ns/1ns

module fsq_pointers #(
    parameter int FSQ_SIZE = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enq,
    input  logic                          issue,
    input  logic                          retire,
    input  logic                          redirect_en,
    input  logic [$clog2(FSQ_SIZE)-1:0]   redirect_idx,
    output logic [$clog2(FSQ_SIZE)-1:0]   tail,
    output logic [$clog2(FSQ_SIZE)-1:0]   search_head,
    output logic [$clog2(FSQ_SIZE)-1:0]   commit_head,
    output logic                          full,
    output logic                          search_valid
);

    localparam int IDX_W = $clog2(FSQ_SIZE);
    localparam logic [IDX_W:0] PTR_ONE = 1;

    // msb of each pointer is the wrap bit
    logic [IDX_W:0] tail_ptr;
    logic [IDX_W:0] search_ptr;
    logic [IDX_W:0] commit_ptr;
    logic [IDX_W:0] redirect_ptr;
    logic           rd_wrap;
    logic           empty;
    logic [IDX_W-1:0] rd_dist;
    logic [IDX_W:0]   live_cnt;

    assign tail        = tail_ptr[IDX_W-1:0];
    assign search_head = search_ptr[IDX_W-1:0];
    assign commit_head = commit_ptr[IDX_W-1:0];

    assign full  = (tail_ptr[IDX_W-1:0] == commit_ptr[IDX_W-1:0]) &&
                   (tail_ptr[IDX_W] != commit_ptr[IDX_W]);
    assign empty = tail_ptr == commit_ptr;

    // streams written but not yet handed to the cache
    assign search_valid = search_ptr != tail_ptr;

    // a live index below the commit head has wrapped past it
    assign rd_wrap = (redirect_idx >= commit_ptr[IDX_W-1:0]) ?
                     commit_ptr[IDX_W] : ~commit_ptr[IDX_W];
    assign redirect_ptr = {rd_wrap, redirect_idx} + PTR_ONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_ptr <= '0;
        end
        else if (redirect_en) begin
            tail_ptr <= redirect_ptr;
        end
        else if (enq) begin
            tail_ptr <= tail_ptr + PTR_ONE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_ptr <= '0;
        end
        else if (redirect_en) begin
            // younger streams are dropped, restart right after the branch
            search_ptr <= redirect_ptr;
        end
        else if (issue) begin
            search_ptr <= search_ptr + PTR_ONE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_ptr <= '0;
        end
        else if (retire) begin
            commit_ptr <= commit_ptr + PTR_ONE;
        end
    end

    assign rd_dist  = redirect_idx - commit_ptr[IDX_W-1:0];
    assign live_cnt = tail_ptr - commit_ptr;

    a_no_enq_full: assert property (
        @(posedge clk) disable iff (rst)
        enq |-> !full
    ) else $error("fsq_pointers: enqueue into full queue");

    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (rst)
        retire |-> !empty
    ) else $error("fsq_pointers: retire from empty queue");

    // backend may only name a stream between commit head and tail
    a_redirect_live: assert property (
        @(posedge clk) disable iff (rst)
        redirect_en |-> ({1'b0, rd_dist} < live_cnt)
    ) else $error("fsq_pointers: redirect to a dead entry");

endmodule

// File: fsq_ram.sv
`timescale 1ns/1ns

module fsq_ram #(
    parameter int FSQ_SIZE = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               we,
    input  logic [$clog2(FSQ_SIZE)-1:0]        waddr,
    input  fsq_pkg::fetch_stream_t             wdata,
    input  logic [$clog2(FSQ_SIZE)-1:0]        search_addr,
    input  logic [$clog2(FSQ_SIZE)-1:0]        commit_addr,
    output fsq_pkg::fetch_stream_t             search_data,
    output fsq_pkg::fetch_stream_t             commit_data
);

    fsq_pkg::fetch_stream_t mem [FSQ_SIZE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < FSQ_SIZE; i++) begin
                mem[i] <= '0;
            end
        end
        else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both reads are combinational
    assign search_data = mem[search_addr];
    assign commit_data = mem[commit_addr];

    a_waddr_known: assert property (
        @(posedge clk) disable iff (rst)
        we |-> !$isunknown(waddr)
    ) else $error("fsq_ram: write with unknown address");

endmodule

// File: fsq_pkg.sv
package fsq_pkg;

    // virtual address width
    localparam int VADDR_SIZE = 32;

    // offset of an instruction inside one stream
    localparam int PREDICTION_WIDTH = 3;

    // instructions a single stream can hold
    localparam int BLOCK_INSTS = 1 << PREDICTION_WIDTH;

    typedef enum logic [2:0] {
        CONDITION = 3'd0,
        DIRECT    = 3'd1,
        INDIRECT  = 3'd2,
        CALL      = 3'd3,
        RET       = 3'd4
    } br_type_e;

    // one predicted fetch block
    typedef struct packed {
        logic [VADDR_SIZE-1:0]       start_addr;
        logic [VADDR_SIZE-1:0]       target;
        logic [PREDICTION_WIDTH-1:0] size;
        logic                        taken;
    } fetch_stream_t;

    // backend resolution of a mispredicted branch
    typedef struct packed {
        logic                        taken;
        br_type_e                    br_type;
        logic [VADDR_SIZE-1:0]       target;
        logic [PREDICTION_WIDTH-1:0] offset;
    } wb_info_t;

endpackage
